// ==== dv/mem_ctrl_trace.txt ====
# op addr data expected, all hex; R drives data onto ppu_status, V data is {h_mirror, v_mirror}
# J puts addr on joycon_1 and data on joycon_2; D waits for the DMA that W 4014 started
W 0012 005A 0000
W 07FF 00C3 0000
R 0812 0000 005A
R 1FFF 0000 00C3
W 1813 0077 0000
R 0013 0000 0077
R 5000 0000 0000
W 2001 001E 0000
A 2001 0000 001E
W 2005 0012 0000
W 2005 0034 0000
A 2005 0000 1234
W 2005 0056 0000
R 3FFA 00A0 00A0
W 2005 0078 0000
W 2005 009A 0000
A 2005 0000 789A
W 2006 0020 0000
W 2006 0000 0000
W 2007 0011 0000
W 2007 0022 0000
W 2000 0004 0000
A 2000 0000 0004
W 2006 0024 0000
W 2006 0005 0000
W 2007 0033 0000
W 2007 0044 0000
W 2006 0028 0000
W 2006 0010 0000
W 2007 0055 0000
V 2401 0002 0022
V 2C05 0002 0033
V 2010 0002 0055
V 2800 0001 0011
V 2425 0001 0044
V 2401 0003 0022
W 2003 0010 0000
W 2004 00A1 0000
W 2004 00B2 0000
S 0010 0000 00A1
S 0011 0000 00B2
W 2003 0000 0000
W 4014 0003 0000
D 0000 0003 0200
J 00A5 003C 0000
W 4016 0001 0000
W 4016 0000 0000
R 4016 0000 0001
R 4017 0000 0000
R 4016 0000 0000
R 4017 0000 0000
R 4016 0000 0001
R 4016 0000 0000
R 4016 0000 0000
R 4016 0000 0001
R 4016 0000 0000
R 4016 0000 0001
R 4016 0000 0001
R 4017 0000 0001

// ==== list.f ====
rtl/nes_mem_pkg.sv
rtl/joypad_port.sv
rtl/oam_dma.sv
rtl/mem_decode.sv
rtl/mem_ctrl.sv
dv/mem_ctrl_tb.sv

// ==== Bender.yml ====
package:
  name: nes_mem_ctrl

sources:
  - rtl/nes_mem_pkg.sv
  - rtl/joypad_port.sv
  - rtl/oam_dma.sv
  - rtl/mem_decode.sv
  - rtl/mem_ctrl.sv
  - target: test
    files:
      - dv/mem_ctrl_tb.sv

// ==== dv/mem_ctrl_tb.sv ====
// Trace-driven testbench for mem_ctrl; compile with list.f and run mem_ctrl_tb as the top
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl_tb;

	// Source page of the OAM DMA, filled with random bytes before the trace runs
	localparam logic [7:0] dma_src_page = 8'h03;
	localparam int         op_budget    = 600;

	logic        clk;
	logic        rst_n;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_data_in;
	logic [7:0]  cpu_data_out;
	logic        cpu_write_en;
	logic        cpu_read_en;
	logic [7:0]  ppu_ctrl1;
	logic [7:0]  ppu_ctrl2;
	logic [7:0]  ppu_status;
	logic [15:0] ppu_scroll_addr;
	logic [15:0] vram_ppu_addr;
	logic [7:0]  vram_ppu_data;
	logic [7:0]  spram_ppu_addr;
	logic [7:0]  spram_ppu_data;
	logic [7:0]  spram_cpu_addr;
	logic        ppu_status_read;
	logic [7:0]  joycon_1;
	logic [7:0]  joycon_2;
	logic        busy;
	logic        h_mirror;
	logic        v_mirror;

	integer      seed;
	int          error_count;
	int          check_count;
	int          busy_run;
	int          busy_len;
	logic        trace_loaded;
	logic [7:0]  src_page [256];
	logic [7:0]  oam_addr_exp;

	// One entry per trace operation
	logic [7:0]  op_q [$];
	logic [15:0] addr_q [$];
	logic [15:0] data_q [$];
	logic [15:0] exp_q [$];
	int          line_q [$];

	mem_ctrl mem_ctrl_i (
		.clk             (clk),
		.rst_n           (rst_n),
		.cpu_addr        (cpu_addr),
		.cpu_data_in     (cpu_data_in),
		.cpu_data_out    (cpu_data_out),
		.cpu_write_en    (cpu_write_en),
		.cpu_read_en     (cpu_read_en),
		.ppu_ctrl1       (ppu_ctrl1),
		.ppu_ctrl2       (ppu_ctrl2),
		.ppu_status      (ppu_status),
		.ppu_scroll_addr (ppu_scroll_addr),
		.vram_ppu_addr   (vram_ppu_addr),
		.vram_ppu_data   (vram_ppu_data),
		.spram_ppu_addr  (spram_ppu_addr),
		.spram_ppu_data  (spram_ppu_data),
		.spram_cpu_addr  (spram_cpu_addr),
		.ppu_status_read (ppu_status_read),
		.joycon_1        (joycon_1),
		.joycon_2        (joycon_2),
		.busy            (busy),
		.h_mirror        (h_mirror),
		.v_mirror        (v_mirror)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Length of the last busy run, sampled before each rising edge
	always @(posedge clk) begin
		if (busy) begin
			busy_run <= busy_run + 1;
		end else if (busy_run != 0) begin
			busy_len <= busy_run;
			busy_run <= 0;
		end
	end

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic load_trace();
		integer         fd;
		integer         c;
		integer         n;
		int             line_no;
		logic [15:0]    a;
		logic [15:0]    d;
		logic [15:0]    e;
		reg [8*128-1:0] rest;
		line_no = 0;
		fd = $fopen("dv/mem_ctrl_trace.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("Cannot open the trace file dv/mem_ctrl_trace.txt");
		end else begin
			c = $fgetc(fd);
			while (c != -1) begin
				line_no++;
				if (c == "#") begin
					n = $fgets(rest, fd);
				end else if (c != "\n") begin
					n = $fscanf(fd, "%h %h %h", a, d, e);
					if (n == 3) begin
						op_q.push_back(c[7:0]);
						addr_q.push_back(a);
						data_q.push_back(d);
						exp_q.push_back(e);
						line_q.push_back(line_no);
					end else begin
						error_count++;
						$display("Trace line %0d could not be parsed", line_no);
					end
					n = $fgets(rest, fd);
				end
				c = $fgetc(fd);
			end
			$fclose(fd);
		end
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_data_in = data;
		cpu_write_en = 1'b1;
		@(negedge clk);
		cpu_write_en = 1'b0;
	endtask

	task automatic cpu_read(input string name, input logic [15:0] addr, input logic [7:0] status,
			input logic [15:0] expected);
		logic hit;
		// Status register and its mirrors every 8 bytes up to 0x3FFF
		hit = addr[15:13] == 3'b001 && addr[2:0] == 3'd2;
		cpu_addr = addr;
		ppu_status = status;
		cpu_read_en = 1'b1;
		@(negedge clk);
		cpu_read_en = 1'b0;
		check_value(name, expected, {8'h00, cpu_data_out});
		check_value({name, " status pulse"}, {15'd0, hit}, {15'd0, ppu_status_read});
	endtask

	task automatic fill_dma_page();
		int          i;
		logic [31:0] rnd;
		for (i = 0; i < 256; i++) begin
			rnd = $random(seed);
			src_page[i] = rnd[7:0];
			cpu_write({dma_src_page, 8'(i)}, src_page[i]);
		end
	endtask

	task automatic wait_dma_done(input string name, input logic [15:0] expected_len);
		int i;
		while (busy)
			@(negedge clk);
		// One more edge so the counter records the finished run
		@(negedge clk);
		check_value(name, expected_len, 16'(busy_len));
		for (i = 0; i < 256; i++) begin
			spram_ppu_addr = 8'(i);
			@(negedge clk);
			check_value($sformatf("%s sprite byte %0d", name, i), {8'h00, src_page[i]},
				{8'h00, spram_ppu_data});
		end
	endtask

	task automatic check_ppu_reg(input string name, input logic [15:0] addr,
			input logic [15:0] expected);
		case (addr)
			16'h2000: check_value(name, expected, {8'h00, ppu_ctrl1});
			16'h2001: check_value(name, expected, {8'h00, ppu_ctrl2});
			16'h2005: check_value(name, expected, ppu_scroll_addr);
			default: begin
				error_count++;
				$display("No PPU register output for address %h in %s", addr, name);
			end
		endcase
	endtask

	task automatic run_op(input int k);
		string name;
		name = $sformatf("trace line %0d", line_q[k]);
		case (op_q[k])
			"W": begin
				cpu_write(addr_q[k], data_q[k][7:0]);
				// OAM address loads on 0x2003 and steps on 0x2004, both mirrored every 8 bytes
				if (addr_q[k][15:13] == 3'b001 && addr_q[k][2:0] == 3'd3)
					oam_addr_exp = data_q[k][7:0];
				else if (addr_q[k][15:13] == 3'b001 && addr_q[k][2:0] == 3'd4)
					oam_addr_exp = oam_addr_exp + 8'd1;
				check_value({name, " OAM address"}, {8'h00, oam_addr_exp},
					{8'h00, spram_cpu_addr});
			end
			"R": cpu_read(name, addr_q[k], data_q[k][7:0], exp_q[k]);
			"D": wait_dma_done(name, exp_q[k]);
			"S": begin
				spram_ppu_addr = addr_q[k][7:0];
				@(negedge clk);
				check_value(name, exp_q[k], {8'h00, spram_ppu_data});
			end
			"V": begin
				h_mirror = data_q[k][1];
				v_mirror = data_q[k][0];
				vram_ppu_addr = addr_q[k];
				@(negedge clk);
				check_value(name, exp_q[k], {8'h00, vram_ppu_data});
			end
			"J": begin
				joycon_1 = addr_q[k][7:0];
				joycon_2 = data_q[k][7:0];
			end
			"A": check_ppu_reg(name, addr_q[k], exp_q[k]);
			default: begin
				error_count++;
				$display("Unknown opcode in %s", name);
			end
		endcase
	endtask

	// Budget per trace operation, plus one for reset and the page fill
	initial begin : watchdog
		int limit;
		wait (trace_loaded);
		limit = (op_q.size() + 1) * op_budget;
		repeat (limit) @(posedge clk);
		$display("Timeout: the trace did not finish within %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		int i;
		seed = 97;
		error_count = 0;
		check_count = 0;
		busy_run = 0;
		busy_len = 0;
		oam_addr_exp = '0;
		trace_loaded = 1'b0;
		rst_n = 1'b0;
		cpu_addr = '0;
		cpu_data_in = '0;
		cpu_write_en = 1'b0;
		cpu_read_en = 1'b0;
		ppu_status = '0;
		vram_ppu_addr = '0;
		spram_ppu_addr = '0;
		joycon_1 = '0;
		joycon_2 = '0;
		h_mirror = 1'b0;
		v_mirror = 1'b0;
		load_trace();
		trace_loaded = 1'b1;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		fill_dma_page();
		for (i = 0; i < op_q.size(); i++)
			run_op(i);
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/mem_ctrl.sv ====
// Memory controller top; muxes CPU and OAM DMA onto the decoder and hosts both joypad ports
`timescale 1ns/10ps
`default_nettype none

module mem_ctrl (
	input  wire                              clk,
	input  wire                              rst_n,
	// CPU bus
	input  wire  [nes_mem_pkg::addr_w-1:0]   cpu_addr,
	input  wire  [nes_mem_pkg::data_w-1:0]   cpu_data_in,
	output logic [nes_mem_pkg::data_w-1:0]   cpu_data_out,
	input  wire                              cpu_write_en,
	input  wire                              cpu_read_en,
	// PPU side
	output logic [nes_mem_pkg::data_w-1:0]   ppu_ctrl1,
	output logic [nes_mem_pkg::data_w-1:0]   ppu_ctrl2,
	input  wire  [nes_mem_pkg::data_w-1:0]   ppu_status,
	output logic [nes_mem_pkg::addr_w-1:0]   ppu_scroll_addr,
	input  wire  [nes_mem_pkg::addr_w-1:0]   vram_ppu_addr,
	output logic [nes_mem_pkg::data_w-1:0]   vram_ppu_data,
	input  wire  [nes_mem_pkg::spram_aw-1:0] spram_ppu_addr,
	output logic [nes_mem_pkg::data_w-1:0]   spram_ppu_data,
	output logic [nes_mem_pkg::spram_aw-1:0] spram_cpu_addr,
	output logic                             ppu_status_read,
	// One bit per button
	input  wire  [nes_mem_pkg::data_w-1:0]   joycon_1,
	input  wire  [nes_mem_pkg::data_w-1:0]   joycon_2,
	output logic                             busy,
	input  wire                              h_mirror,
	input  wire                              v_mirror
);

	logic [nes_mem_pkg::addr_w-1:0] mem_addr;
	logic [nes_mem_pkg::data_w-1:0] mem_data_in;
	logic [nes_mem_pkg::data_w-1:0] mem_data_out;
	logic                           mem_write_en;
	logic                           mem_read_en;
	logic [nes_mem_pkg::addr_w-1:0] dma_addr;
	logic [nes_mem_pkg::data_w-1:0] dma_data;
	logic                           dma_write_en;
	logic                           dma_read_en;
	logic                           joy_strobe_write;
	logic                           joy_latch;
	logic                           joy1_read;
	logic                           joy2_read;
	logic                           joy1_bit;
	logic                           joy2_bit;

	// DMA owns the decoder while busy, CPU strobes are dropped
	assign mem_addr     = busy ? dma_addr : cpu_addr;
	assign mem_data_in  = busy ? dma_data : cpu_data_in;
	assign mem_write_en = busy ? dma_write_en : cpu_write_en;
	assign mem_read_en  = busy ? dma_read_en : cpu_read_en;

	// Registered decoder data goes to both CPU and DMA
	assign cpu_data_out = mem_data_out;

	mem_decode mem_decode_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.mem_addr         (mem_addr),
		.mem_data_in      (mem_data_in),
		.mem_data_out     (mem_data_out),
		.mem_write_en     (mem_write_en),
		.mem_read_en      (mem_read_en),
		.ppu_ctrl1        (ppu_ctrl1),
		.ppu_ctrl2        (ppu_ctrl2),
		.ppu_status       (ppu_status),
		.ppu_scroll_addr  (ppu_scroll_addr),
		.vram_ppu_addr    (vram_ppu_addr),
		.vram_ppu_data    (vram_ppu_data),
		.spram_ppu_addr   (spram_ppu_addr),
		.spram_ppu_data   (spram_ppu_data),
		.spram_cpu_addr   (spram_cpu_addr),
		.ppu_status_read  (ppu_status_read),
		.h_mirror         (h_mirror),
		.v_mirror         (v_mirror),
		.joy1_bit         (joy1_bit),
		.joy2_bit         (joy2_bit),
		.joy_strobe_write (joy_strobe_write),
		.joy_latch        (joy_latch),
		.joy1_read        (joy1_read),
		.joy2_read        (joy2_read)
	);

	// Watches the raw CPU bus for the 0x4014 trigger
	oam_dma oam_dma_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.cpu_addr     (cpu_addr),
		.cpu_data_in  (cpu_data_in),
		.cpu_write_en (cpu_write_en),
		.dma_data_in  (mem_data_out),
		.dma_addr     (dma_addr),
		.dma_data_out (dma_data),
		.dma_write_en (dma_write_en),
		.dma_read_en  (dma_read_en),
		.busy         (busy)
	);

	joypad_port joypad_1 (
		.clk          (clk),
		.rst_n        (rst_n),
		.buttons      (joycon_1),
		.strobe_write (joy_strobe_write),
		.latch        (joy_latch),
		.read         (joy1_read),
		.serial_bit   (joy1_bit)
	);

	joypad_port joypad_2 (
		.clk          (clk),
		.rst_n        (rst_n),
		.buttons      (joycon_2),
		.strobe_write (joy_strobe_write),
		.latch        (joy_latch),
		.read         (joy2_read),
		.serial_bit   (joy2_bit)
	);

endmodule

`default_nettype wire

// ==== rtl/mem_decode.sv ====
// Address decoder holding work RAM, PPU registers, mirrored VRAM and sprite RAM; driven by mem_ctrl
`timescale 1ns/10ps
`default_nettype none

module mem_decode (
	input  wire                                  clk,
	input  wire                                  rst_n,
	input  wire  [nes_mem_pkg::addr_w-1:0]       mem_addr,
	input  wire  [nes_mem_pkg::data_w-1:0]       mem_data_in,
	output logic [nes_mem_pkg::data_w-1:0]       mem_data_out,
	input  wire                                  mem_write_en,
	input  wire                                  mem_read_en,
	output logic [nes_mem_pkg::data_w-1:0]       ppu_ctrl1,
	output logic [nes_mem_pkg::data_w-1:0]       ppu_ctrl2,
	input  wire  [nes_mem_pkg::data_w-1:0]       ppu_status,
	output logic [nes_mem_pkg::addr_w-1:0]       ppu_scroll_addr,
	input  wire  [nes_mem_pkg::addr_w-1:0]       vram_ppu_addr,
	output logic [nes_mem_pkg::data_w-1:0]       vram_ppu_data,
	input  wire  [nes_mem_pkg::spram_aw-1:0]     spram_ppu_addr,
	output logic [nes_mem_pkg::data_w-1:0]       spram_ppu_data,
	output logic [nes_mem_pkg::spram_aw-1:0]     spram_cpu_addr,
	output logic                                 ppu_status_read,
	input  wire                                  h_mirror,
	input  wire                                  v_mirror,
	input  wire                                  joy1_bit,
	input  wire                                  joy2_bit,
	output logic                                 joy_strobe_write,
	output logic                                 joy_latch,
	output logic                                 joy1_read,
	output logic                                 joy2_read
);

	logic [nes_mem_pkg::data_w-1:0] wram  [nes_mem_pkg::wram_words];
	logic [nes_mem_pkg::data_w-1:0] vram  [nes_mem_pkg::vram_words];
	logic [nes_mem_pkg::data_w-1:0] spram [nes_mem_pkg::spram_words];

	logic [nes_mem_pkg::addr_w-1:0]  vram_cpu_addr;
	logic                            write_toggle;
	logic                            wram_sel;
	logic                            ppu_win;
	logic [nes_mem_pkg::addr_w-1:0]  reg_addr;
	logic [nes_mem_pkg::wram_aw-1:0] wram_idx;
	logic [nes_mem_pkg::vram_aw-1:0] vram_cpu_idx;
	logic [nes_mem_pkg::vram_aw-1:0] vram_ppu_idx;
	logic [nes_mem_pkg::data_w-1:0]  rd_data;
	logic                            wr_wram;
	logic                            wr_ctrl1;
	logic                            wr_ctrl2;
	logic                            wr_oam_addr;
	logic                            wr_oam_data;
	logic                            wr_scroll;
	logic                            wr_ppu_addr;
	logic                            wr_ppu_data;
	logic                            rd_status;

	// Nametable fold, h_mirror takes priority; neither set gives one-screen
	function automatic logic [nes_mem_pkg::vram_aw-1:0] vram_fold(
		input logic [nes_mem_pkg::addr_w-1:0] addr,
		input logic                           h,
		input logic                           v
	);
		logic page;
		if (h)
			page = addr[11];
		else if (v)
			page = addr[10];
		else
			page = 1'b0;
		return {page, addr[nes_mem_pkg::vram_aw-2:0]};
	endfunction

	assign wram_sel = mem_addr[15:13] == 3'b000;
	assign ppu_win  = mem_addr[15:13] == 3'b001;

	// Collapse the PPU mirrors onto 0x2000-0x2007
	assign reg_addr = ppu_win ? {3'b001, 10'd0, mem_addr[2:0]} : mem_addr;

	assign wram_idx     = mem_addr[nes_mem_pkg::wram_aw-1:0];
	assign vram_cpu_idx = vram_cpu_addr[nes_mem_pkg::vram_aw-1:0];
	assign vram_ppu_idx = vram_fold(vram_ppu_addr, h_mirror, v_mirror);

	assign wr_wram     = mem_write_en && wram_sel;
	assign wr_ctrl1    = mem_write_en && reg_addr == nes_mem_pkg::ppu_ctrl1_addr;
	assign wr_ctrl2    = mem_write_en && reg_addr == nes_mem_pkg::ppu_ctrl2_addr;
	assign wr_oam_addr = mem_write_en && reg_addr == nes_mem_pkg::oam_addr_addr;
	assign wr_oam_data = mem_write_en && reg_addr == nes_mem_pkg::oam_data_addr;
	assign wr_scroll   = mem_write_en && reg_addr == nes_mem_pkg::ppu_scroll_addr_reg;
	assign wr_ppu_addr = mem_write_en && reg_addr == nes_mem_pkg::ppu_addr_addr;
	assign wr_ppu_data = mem_write_en && reg_addr == nes_mem_pkg::ppu_data_addr;
	assign rd_status   = mem_read_en && reg_addr == nes_mem_pkg::ppu_status_addr;

	// Joypad strobes, both ports share the latch write
	assign joy_strobe_write = mem_write_en && reg_addr == nes_mem_pkg::joy1_addr;
	assign joy_latch        = mem_data_in[0];
	assign joy1_read        = mem_read_en && reg_addr == nes_mem_pkg::joy1_addr;
	assign joy2_read        = mem_read_en && reg_addr == nes_mem_pkg::joy2_addr;

	always_comb begin
		if (wram_sel) begin
			rd_data = wram[wram_idx];
		end else begin
			case (reg_addr)
				nes_mem_pkg::ppu_status_addr: rd_data = ppu_status;
				nes_mem_pkg::oam_data_addr:   rd_data = spram[spram_cpu_addr];
				nes_mem_pkg::ppu_data_addr:   rd_data = vram[vram_cpu_idx];
				nes_mem_pkg::joy1_addr:       rd_data = {{(nes_mem_pkg::data_w-1){1'b0}}, joy1_bit};
				nes_mem_pkg::joy2_addr:       rd_data = {{(nes_mem_pkg::data_w-1){1'b0}}, joy2_bit};
				default:                      rd_data = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ppu_ctrl1       <= '0;
			ppu_ctrl2       <= '0;
			ppu_scroll_addr <= '0;
			vram_cpu_addr   <= '0;
			spram_cpu_addr  <= '0;
			write_toggle    <= 1'b0;
			ppu_status_read <= 1'b0;
			mem_data_out    <= '0;
		end else begin
			ppu_status_read <= rd_status;
			if (wr_ctrl1)
				ppu_ctrl1 <= mem_data_in;
			if (wr_ctrl2)
				ppu_ctrl2 <= mem_data_in;

			// Status read resets the shared 0x2005/0x2006 toggle
			if (rd_status)
				write_toggle <= 1'b0;
			else if (wr_scroll || wr_ppu_addr)
				write_toggle <= !write_toggle;

			// First write high byte, second low byte
			if (wr_scroll) begin
				if (write_toggle)
					ppu_scroll_addr[7:0] <= mem_data_in;
				else
					ppu_scroll_addr[15:8] <= mem_data_in;
			end

			if (wr_ppu_addr) begin
				if (write_toggle)
					vram_cpu_addr[7:0] <= mem_data_in;
				else
					vram_cpu_addr[15:8] <= mem_data_in;
			end else if (wr_ppu_data) begin
				// Step of 32 walks down a nametable column
				vram_cpu_addr <= vram_cpu_addr + (ppu_ctrl1[2] ? 16'd32 : 16'd1);
			end

			if (wr_oam_addr)
				spram_cpu_addr <= mem_data_in;
			else if (wr_oam_data)
				spram_cpu_addr <= spram_cpu_addr + 8'd1;

			if (mem_read_en)
				mem_data_out <= rd_data;
		end
	end

	// Memory arrays and PPU-side read ports
	always_ff @(posedge clk) begin
		if (wr_wram)
			wram[wram_idx] <= mem_data_in;
		if (wr_ppu_data)
			vram[vram_cpu_idx] <= mem_data_in;
		if (wr_oam_data)
			spram[spram_cpu_addr] <= mem_data_in;
		vram_ppu_data  <= vram[vram_ppu_idx];
		spram_ppu_data <= spram[spram_ppu_addr];
	end

endmodule

`default_nettype wire

// ==== rtl/oam_dma.sv ====
// OAM DMA engine copying one 256-byte CPU page into sprite RAM after a write to 0x4014
`timescale 1ns/10ps
`default_nettype none

module oam_dma (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  [nes_mem_pkg::addr_w-1:0] cpu_addr,
	input  wire  [nes_mem_pkg::data_w-1:0] cpu_data_in,
	input  wire                            cpu_write_en,
	input  wire  [nes_mem_pkg::data_w-1:0] dma_data_in,
	output logic [nes_mem_pkg::addr_w-1:0] dma_addr,
	output logic [nes_mem_pkg::data_w-1:0] dma_data_out,
	output logic                           dma_write_en,
	output logic                           dma_read_en,
	output logic                           busy
);

	nes_mem_pkg::dma_state_e        state;
	logic [nes_mem_pkg::data_w-1:0] page;
	logic [7:0]                     byte_cnt;
	logic                           trigger;

	// Trigger only from idle, repeats during a transfer are dropped
	assign trigger = cpu_write_en && cpu_addr == nes_mem_pkg::oam_dma_addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= nes_mem_pkg::dma_idle;
			page     <= '0;
			byte_cnt <= '0;
		end else begin
			case (state)
				nes_mem_pkg::dma_idle: begin
					if (trigger) begin
						page     <= cpu_data_in;
						byte_cnt <= '0;
						state    <= nes_mem_pkg::dma_read;
					end
				end
				nes_mem_pkg::dma_read: begin
					state <= nes_mem_pkg::dma_write;
				end
				nes_mem_pkg::dma_write: begin
					byte_cnt <= byte_cnt + 8'd1;
					// Last byte of the page
					if (byte_cnt == 8'hff)
						state <= nes_mem_pkg::dma_idle;
					else
						state <= nes_mem_pkg::dma_read;
				end
				default: begin
					state <= nes_mem_pkg::dma_idle;
				end
			endcase
		end
	end

	assign busy         = state != nes_mem_pkg::dma_idle;
	assign dma_read_en  = state == nes_mem_pkg::dma_read;
	assign dma_write_en = state == nes_mem_pkg::dma_write;

	// Source byte on read cycles, OAM data port on write cycles
	assign dma_addr = dma_write_en ? nes_mem_pkg::oam_data_addr : {page, byte_cnt};

	// Registered read data from the decoder is valid during the write cycle
	assign dma_data_out = dma_write_en ? dma_data_in : '0;

endmodule

`default_nettype wire

// ==== rtl/joypad_port.sv ====
// Serial joypad port with latch strobe and shift-out on read; one instance per controller
`timescale 1ns/10ps
`default_nettype none

module joypad_port (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire  [nes_mem_pkg::data_w-1:0] buttons,
	input  wire                            strobe_write,
	input  wire                            latch,
	input  wire                            read,
	output logic                           serial_bit
);

	logic [nes_mem_pkg::data_w-1:0] shift_reg;
	logic                           latched;

	// Latch level follows each strobe write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			latched <= 1'b0;
		else if (strobe_write)
			latched <= latch;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			shift_reg <= '0;
		end else if (latched) begin
			// Keep tracking the buttons while latched
			shift_reg <= buttons;
		end else if (read) begin
			// Shift toward bit 0, ones fill in behind
			shift_reg <= {1'b1, shift_reg[nes_mem_pkg::data_w-1:1]};
		end
	end

	// While latched, reads keep seeing the first button
	assign serial_bit = latched ? buttons[0] : shift_reg[0];

endmodule

`default_nettype wire

// ==== rtl/nes_mem_pkg.sv ====
// Shared address map, memory sizes and DMA state type for the NES memory controller blocks
`default_nettype none

package nes_mem_pkg;

	// CPU bus widths
	localparam int addr_w = 16;
	localparam int data_w = 8;

	// Memory depths
	localparam int wram_words  = 2048;
	localparam int vram_words  = 2048;
	localparam int spram_words = 256;

	// Index widths derived from the depths
	localparam int wram_aw  = $clog2(wram_words);
	localparam int vram_aw  = $clog2(vram_words);
	localparam int spram_aw = $clog2(spram_words);

	// PPU register window, repeats every 8 bytes through 0x3FFF
	localparam logic [addr_w-1:0] ppu_ctrl1_addr      = 16'h2000;
	localparam logic [addr_w-1:0] ppu_ctrl2_addr      = 16'h2001;
	localparam logic [addr_w-1:0] ppu_status_addr     = 16'h2002;
	localparam logic [addr_w-1:0] oam_addr_addr       = 16'h2003;
	localparam logic [addr_w-1:0] oam_data_addr       = 16'h2004;
	localparam logic [addr_w-1:0] ppu_scroll_addr_reg = 16'h2005;
	localparam logic [addr_w-1:0] ppu_addr_addr       = 16'h2006;
	localparam logic [addr_w-1:0] ppu_data_addr       = 16'h2007;

	// I/O registers
	localparam logic [addr_w-1:0] oam_dma_addr = 16'h4014;
	localparam logic [addr_w-1:0] joy1_addr    = 16'h4016;
	localparam logic [addr_w-1:0] joy2_addr    = 16'h4017;

	// OAM DMA sequencer states
	typedef enum logic [1:0] {
		dma_idle,
		dma_read,
		dma_write
	} dma_state_e;

endpackage

`default_nettype wire
